/* rtl/recovery_pkg.sv */
package recovery_pkg;

  // Widths that carry a meaning on the recovery RX path
  typedef logic [7:0]  byte_t;
  typedef logic [15:0] cmd_len_t;
  typedef logic [7:0]  pec_t;

  // Count of frames rejected for a bad PEC, wraps
  typedef logic [7:0]  err_count_t;

  // SMBus CRC-8 polynomial x^8 + x^2 + x + 1
  localparam pec_t PecPoly = 8'h07;

  // Payload FIFO sizing
  localparam int unsigned QueueDepth      = 16;
  localparam int unsigned QueueCountWidth = 5;

  // Fill level, counts 0 up to QueueDepth
  typedef logic [QueueCountWidth-1:0] queue_count_t;

endpackage

/* rtl/recovery_cmd_if.sv */
`timescale 1ns/100ps

interface recovery_cmd_if;

  // Decoded command, held from valid until done
  logic                     valid;
  logic                     is_rd;
  recovery_pkg::byte_t      cmd;
  recovery_pkg::cmd_len_t   len;
  logic                     error;

  // Result consumed, receiver may go back to idle
  logic                     done;

  modport receiver (
    output valid, is_rd, cmd, len, error,
    input  done
  );

  modport handler (
    input  valid, is_rd, cmd, len, error,
    output done
  );

endinterface

/* rtl/pec_crc8.sv */
`timescale 1ns/100ps

module pec_crc8 (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                enable_i,
  input  logic                clear_i,
  input  recovery_pkg::byte_t data_i,
  output recovery_pkg::pec_t  crc_o
);

  recovery_pkg::pec_t crc_q;

  // One byte through the CRC-8, MSB first
  function automatic recovery_pkg::pec_t crc8_byte(recovery_pkg::pec_t crc,
                                                   recovery_pkg::byte_t data);
    recovery_pkg::pec_t c;
    c = crc ^ data;
    for (int i = 0; i < 8; i++) begin
      if (c[7]) begin
        c = (c << 1) ^ recovery_pkg::PecPoly;
      end else begin
        c = c << 1;
      end
    end
    return c;
  endfunction

  // Clear wins over a byte in the same cycle
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      crc_q <= '0;
    end else if (clear_i) begin
      crc_q <= '0;
    end else if (enable_i) begin
      crc_q <= crc8_byte(crc_q, data_i);
    end
  end

  assign crc_o = crc_q;

  // A new frame never starts on a byte handshake
  assert property (@(posedge clk_i) disable iff (!rst_ni) !(enable_i && clear_i));

endmodule

/* rtl/recovery_receiver.sv */
`timescale 1ns/100ps

module recovery_receiver (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                rx_valid_i,
  input  recovery_pkg::byte_t rx_data_i,
  output logic                byte_ready_o,
  output logic                route_to_queue_o,
  input  logic                queue_push_i,
  input  logic                bus_start_i,
  input  logic                bus_stop_i,
  input  recovery_pkg::pec_t  pec_i,
  output logic                pec_enable_o,
  recovery_cmd_if.receiver    cmd
);

  typedef enum logic [3:0] {
    StIdle,
    StCmd,
    StLenLo,
    StLenHi,
    StPayload,
    StPec,
    StReadReq,
    StReport,
    StBusy
  } state_e;

  state_e state_q, state_d;

  logic                   rx_flow;
  recovery_pkg::cmd_len_t count_q;
  recovery_pkg::byte_t    cmd_q;
  recovery_pkg::byte_t    len_lo_q;
  recovery_pkg::byte_t    len_hi_q;
  recovery_pkg::pec_t     pec_recv_q;
  recovery_pkg::pec_t     pec_calc_q;
  logic                   valid_q;
  logic                   is_rd_q;

  // Byte taken by the receiver itself (header or PEC)
  assign rx_flow = rx_valid_i && byte_ready_o;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q <= StIdle;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      StIdle: begin
        if (bus_start_i) state_d = StCmd;
      end
      StCmd: begin
        if (rx_flow) state_d = StLenLo;
        else if (bus_stop_i) state_d = StIdle;
      end
      StLenLo: begin
        if (rx_flow) state_d = StLenHi;
        else if (bus_stop_i) state_d = StIdle;
      end
      StLenHi: begin
        // Zero length goes straight to the PEC byte
        if (rx_flow) state_d = ({rx_data_i, len_lo_q} == '0) ? StPec : StPayload;
        else if (bus_start_i) state_d = StReadReq;
        else if (bus_stop_i) state_d = StIdle;
      end
      StPayload: begin
        if (queue_push_i && count_q == 16'd1) state_d = StPec;
      end
      StPec: begin
        if (rx_flow) state_d = StReport;
        else if (bus_stop_i) state_d = StIdle;
      end
      StReadReq: state_d = StBusy;
      StReport:  state_d = StBusy;
      StBusy: begin
        if (cmd.done) state_d = StIdle;
      end
      default: state_d = StIdle;
    endcase
  end

  assign byte_ready_o = (state_q == StCmd) || (state_q == StLenLo) ||
                        (state_q == StLenHi) || (state_q == StPec);

  // Payload goes to the queue only while in the payload state
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      route_to_queue_o <= 1'b1;
    end else begin
      route_to_queue_o <= (state_d != StPayload);
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == StLenHi && rx_flow) begin
      count_q <= {rx_data_i, len_lo_q};
    end else if (state_q == StPayload && queue_push_i) begin
      count_q <= count_q - 16'd1;
    end
  end

  // Header and PEC capture
  always_ff @(posedge clk_i) begin
    unique case (state_q)
      StCmd: if (rx_flow) cmd_q <= rx_data_i;
      StLenLo: begin
        if (rx_flow) begin
          len_lo_q   <= rx_data_i;
          // Running CRC over the command byte, kept for a read
          pec_calc_q <= pec_i;
        end
      end
      StLenHi: if (rx_flow) len_hi_q <= rx_data_i;
      StPec: begin
        if (rx_flow) begin
          pec_recv_q <= rx_data_i;
          pec_calc_q <= pec_i;
        end
      end
      StReadReq: begin
        // Byte after the command was the PEC of the read
        pec_recv_q <= len_lo_q;
        len_lo_q   <= '0;
        len_hi_q   <= '0;
      end
      default: ;
    endcase
  end

  assign pec_enable_o = route_to_queue_o ? rx_flow : queue_push_i;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      is_rd_q <= 1'b0;
    end else begin
      valid_q <= (state_q == StReport) || (state_q == StReadReq);
      if (state_q == StReport || state_q == StReadReq) begin
        is_rd_q <= (state_q == StReadReq);
      end
    end
  end

  assign cmd.valid = valid_q;
  assign cmd.is_rd = is_rd_q;
  assign cmd.cmd   = cmd_q;
  assign cmd.len   = {len_hi_q, len_lo_q};
  assign cmd.error = (pec_calc_q != pec_recv_q);

  assert property (@(posedge clk_i) disable iff (!rst_ni) cmd.valid |=> !cmd.valid);

endmodule

/* rtl/payload_queue.sv */
`timescale 1ns/100ps

module payload_queue (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                route_to_queue_i,
  input  logic                rx_valid_i,
  input  recovery_pkg::byte_t rx_data_i,
  input  logic                rx_byte_ready_i,
  output logic                rx_ready_o,
  output logic                push_o,
  input  logic                flush_i,
  input  logic                pop_i,
  output logic                valid_o,
  output recovery_pkg::byte_t data_o
);

  localparam int unsigned PtrWidth = $clog2(recovery_pkg::QueueDepth);

  recovery_pkg::byte_t        mem_q [recovery_pkg::QueueDepth];
  logic [PtrWidth-1:0]        wr_ptr_q;
  logic [PtrWidth-1:0]        rd_ptr_q;
  recovery_pkg::queue_count_t count_q;
  logic                       full;
  logic                       pop;

  assign full = (count_q == recovery_pkg::queue_count_t'(recovery_pkg::QueueDepth));

  // Receiver owns the stream outside the payload
  assign rx_ready_o = route_to_queue_i ? rx_byte_ready_i : !full;
  assign push_o     = !route_to_queue_i && rx_valid_i && !full;
  assign pop        = pop_i && valid_o;

  always_ff @(posedge clk_i) begin
    if (push_o) begin
      mem_q[wr_ptr_q] <= rx_data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni || flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_o) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop) rd_ptr_q <= rd_ptr_q + 1'b1;
      if (push_o && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push_o) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Head byte shows as soon as it is written
  assign valid_o = (count_q != '0);
  assign data_o  = mem_q[rd_ptr_q];

  // Fill level never runs past the depth
  assert property (@(posedge clk_i) disable iff (!rst_ni) count_q <= recovery_pkg::QueueDepth);
  assert property (@(posedge clk_i) disable iff (!rst_ni) pop_i |-> valid_o);

endmodule

/* rtl/recovery_cmd_handler.sv */
`timescale 1ns/100ps

module recovery_cmd_handler (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  recovery_cmd_if.handler          cmd,
  output logic                     result_valid_o,
  output recovery_pkg::byte_t      result_cmd_o,
  output recovery_pkg::cmd_len_t   result_len_o,
  output logic                     result_is_rd_o,
  output logic                     result_error_o,
  input  logic                     result_ack_i,
  output recovery_pkg::err_count_t error_count_o,
  output logic                     flush_o
);

  logic                     ack;
  recovery_pkg::err_count_t err_count_q;

  assign ack = result_ack_i && result_valid_o;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      result_valid_o <= 1'b0;
    end else if (cmd.valid) begin
      result_valid_o <= 1'b1;
    end else if (ack) begin
      result_valid_o <= 1'b0;
    end
  end

  // Result fields follow the command, held until the next one
  always_ff @(posedge clk_i) begin
    if (cmd.valid) begin
      result_cmd_o   <= cmd.cmd;
      result_len_o   <= cmd.len;
      result_is_rd_o <= cmd.is_rd;
      result_error_o <= cmd.error;
    end
  end

  // Release the receiver in the ack cycle
  assign cmd.done = ack;

  // A rejected frame drops whatever payload it queued
  assign flush_o = ack && result_error_o;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      err_count_q <= '0;
    end else if (flush_o) begin
      err_count_q <= err_count_q + 1'b1;
    end
  end

  assign error_count_o = err_count_q;

  assert property (@(posedge clk_i) disable iff (!rst_ni) result_ack_i |-> result_valid_o);

endmodule

/* rtl/recovery_rx_top.sv */
`timescale 1ns/100ps

module recovery_rx_top (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     rx_valid_i,
  output logic                     rx_ready_o,
  input  recovery_pkg::byte_t      rx_data_i,
  input  logic                     bus_start_i,
  input  logic                     bus_stop_i,
  output logic                     result_valid_o,
  output recovery_pkg::byte_t      result_cmd_o,
  output recovery_pkg::cmd_len_t   result_len_o,
  output logic                     result_is_rd_o,
  output logic                     result_error_o,
  input  logic                     result_ack_i,
  output recovery_pkg::err_count_t error_count_o,
  output logic                     payload_valid_o,
  output recovery_pkg::byte_t      payload_data_o,
  input  logic                     payload_pop_i
);

  logic               byte_ready;
  logic               route_to_queue;
  logic               queue_push;
  logic               pec_enable;
  recovery_pkg::pec_t pec_crc;
  logic               flush;

  recovery_cmd_if cmd_if ();

  recovery_receiver i_recovery_receiver (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .rx_valid_i       (rx_valid_i),
    .rx_data_i        (rx_data_i),
    .byte_ready_o     (byte_ready),
    .route_to_queue_o (route_to_queue),
    .queue_push_i     (queue_push),
    .bus_start_i      (bus_start_i),
    .bus_stop_i       (bus_stop_i),
    .pec_i            (pec_crc),
    .pec_enable_o     (pec_enable),
    .cmd              (cmd_if.receiver)
  );

  // CRC restarts on every start, repeated ones included
  pec_crc8 i_pec_crc8 (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .enable_i (pec_enable),
    .clear_i  (bus_start_i),
    .data_i   (rx_data_i),
    .crc_o    (pec_crc)
  );

  payload_queue i_payload_queue (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .route_to_queue_i (route_to_queue),
    .rx_valid_i       (rx_valid_i),
    .rx_data_i        (rx_data_i),
    .rx_byte_ready_i  (byte_ready),
    .rx_ready_o       (rx_ready_o),
    .push_o           (queue_push),
    .flush_i          (flush),
    .pop_i            (payload_pop_i),
    .valid_o          (payload_valid_o),
    .data_o           (payload_data_o)
  );

  recovery_cmd_handler i_recovery_cmd_handler (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .cmd            (cmd_if.handler),
    .result_valid_o (result_valid_o),
    .result_cmd_o   (result_cmd_o),
    .result_len_o   (result_len_o),
    .result_is_rd_o (result_is_rd_o),
    .result_error_o (result_error_o),
    .result_ack_i   (result_ack_i),
    .error_count_o  (error_count_o),
    .flush_o        (flush)
  );

endmodule

/* bench/recovery_rx_tb.sv */
`timescale 1ns/100ps

module recovery_rx_tb;

  localparam int WaitLimit   = 200;
  localparam int AbortWindow = 20;
  localparam int NumFrames   = 14;

  typedef enum logic [1:0] {KindWrite, KindRead, KindAbort} kind_e;

  // For an aborted frame, len is how many length bytes go out before the stop
  typedef struct packed {
    kind_e                  kind;
    recovery_pkg::byte_t    cmd;
    recovery_pkg::cmd_len_t len;
    logic                   corrupt;
  } frame_t;

  localparam frame_t Frames [NumFrames] = '{
    '{KindWrite, 8'h26, 16'd4,  1'b0},
    '{KindWrite, 8'h27, 16'd12, 1'b0},
    '{KindWrite, 8'h28, 16'd6,  1'b1},
    '{KindRead,  8'h22, 16'd0,  1'b0},
    '{KindRead,  8'h23, 16'd0,  1'b1},
    '{KindWrite, 8'h2a, 16'd0,  1'b0},
    '{KindAbort, 8'h26, 16'd0,  1'b0},
    '{KindWrite, 8'h2b, 16'd3,  1'b0},
    '{KindAbort, 8'h27, 16'd1,  1'b0},
    '{KindWrite, 8'h2c, 16'd8,  1'b0},
    '{KindWrite, 8'h2d, 16'd0,  1'b1},
    '{KindRead,  8'h25, 16'd0,  1'b0},
    '{KindWrite, 8'h2e, 16'd1,  1'b0},
    '{KindWrite, 8'h2f, 16'd5,  1'b1}
  };

  logic                     clk_i = 1'b0;
  logic                     rst_ni;
  logic                     rx_valid_i;
  logic                     rx_ready_o;
  recovery_pkg::byte_t      rx_data_i;
  logic                     bus_start_i;
  logic                     bus_stop_i;
  logic                     result_valid_o;
  recovery_pkg::byte_t      result_cmd_o;
  recovery_pkg::cmd_len_t   result_len_o;
  logic                     result_is_rd_o;
  logic                     result_error_o;
  logic                     result_ack_i;
  recovery_pkg::err_count_t error_count_o;
  logic                     payload_valid_o;
  recovery_pkg::byte_t      payload_data_o;
  logic                     payload_pop_i;

  int                       errors;
  int                       failed_tests;
  logic                     timed_out;
  recovery_pkg::err_count_t exp_count;
  recovery_pkg::byte_t      payload_q [$];

  always #2 clk_i = ~clk_i;

  recovery_rx_top i_recovery_rx_top (.*);

  // SMBus CRC-8 fed one data bit at a time, MSB first
  task automatic crc8_update(inout recovery_pkg::pec_t crc, input recovery_pkg::byte_t data);
    logic fb;
    for (int i = 7; i >= 0; i--) begin
      fb  = crc[7] ^ data[i];
      crc = {crc[6:0], 1'b0};
      if (fb) crc = crc ^ 8'h07;
    end
  endtask

  // Inputs change half a nanosecond after the rising edge
  task automatic step();
    @(posedge clk_i);
    #0.5;
  endtask

  task automatic pulse_bus(input logic start);
    bus_start_i = start;
    bus_stop_i  = !start;
    step();
    bus_start_i = 1'b0;
    bus_stop_i  = 1'b0;
  endtask

  task automatic send_byte(input recovery_pkg::byte_t data);
    int n;
    if (timed_out) return;
    repeat ($urandom % 3) step();
    rx_valid_i = 1'b1;
    rx_data_i  = data;
    n = 0;
    @(negedge clk_i);
    while (!rx_ready_o && n < WaitLimit) begin
      @(negedge clk_i);
      n++;
    end
    if (!rx_ready_o) begin
      $display("Timed out waiting for rx_ready_o to take byte %02h", data);
      timed_out = 1'b1;
      errors++;
    end
    step();
    rx_valid_i = 1'b0;
  endtask

  task automatic wait_result();
    int n;
    n = 0;
    @(negedge clk_i);
    while (!result_valid_o && n < WaitLimit) begin
      @(negedge clk_i);
      n++;
    end
    if (!result_valid_o) begin
      $display("Timed out waiting for result_valid_o");
      timed_out = 1'b1;
      errors++;
    end
  endtask

  task automatic wait_payload();
    int n;
    n = 0;
    @(negedge clk_i);
    while (!payload_valid_o && n < WaitLimit) begin
      @(negedge clk_i);
      n++;
    end
    if (!payload_valid_o) begin
      $display("Timed out waiting for payload_valid_o");
      timed_out = 1'b1;
      errors++;
    end
  endtask

  task automatic check_result(input recovery_pkg::byte_t cmd, input recovery_pkg::cmd_len_t len,
                              input logic is_rd, input logic error);
    if (result_cmd_o !== cmd || result_len_o !== len ||
        result_is_rd_o !== is_rd || result_error_o !== error) begin
      $display("ERROR at %0t: result cmd %02h len %0d rd %b err %b, expected %02h %0d %b %b",
               $time, result_cmd_o, result_len_o, result_is_rd_o, result_error_o,
               cmd, len, is_rd, error);
      errors++;
    end
  endtask

  task automatic check_payload(input recovery_pkg::byte_t exp);
    if (payload_data_o !== exp) begin
      $display("ERROR at %0t: payload byte %02h, expected %02h", $time, payload_data_o, exp);
      errors++;
    end
  endtask

  task automatic check_count(input recovery_pkg::err_count_t exp);
    if (error_count_o !== exp) begin
      $display("ERROR at %0t: error count %0d, expected %0d", $time, error_count_o, exp);
      errors++;
    end
  endtask

  task automatic acknowledge();
    step();
    result_ack_i = 1'b1;
    step();
    result_ack_i = 1'b0;
    @(negedge clk_i);
    check_count(exp_count);
    if (result_valid_o) begin
      $display("ERROR at %0t: result_valid_o still high after acknowledge", $time);
      errors++;
    end
  endtask

  // Rejected frames lose their payload on acknowledge
  task automatic drain_payload(input logic flushed);
    if (flushed) payload_q.delete();
    while (payload_q.size() > 0 && !timed_out) begin
      wait_payload();
      if (!timed_out) check_payload(payload_q.pop_front());
      step();
      payload_pop_i = !timed_out;
      step();
      payload_pop_i = 1'b0;
    end
    @(negedge clk_i);
    if (payload_valid_o) begin
      $display("ERROR at %0t: payload left in the queue", $time);
      errors++;
    end
    step();
  endtask

  task automatic send_write(input frame_t f);
    recovery_pkg::pec_t  crc;
    recovery_pkg::byte_t b;
    crc = '0;
    pulse_bus(1'b1);
    send_byte(f.cmd);
    crc8_update(crc, f.cmd);
    send_byte(f.len[7:0]);
    crc8_update(crc, f.len[7:0]);
    send_byte(f.len[15:8]);
    crc8_update(crc, f.len[15:8]);
    for (int i = 0; i < int'(f.len); i++) begin
      b = recovery_pkg::byte_t'($urandom);
      payload_q.push_back(b);
      send_byte(b);
      crc8_update(crc, b);
    end
    send_byte(f.corrupt ? crc ^ 8'h5a : crc);
    pulse_bus(1'b0);
  endtask

  // Command and PEC, then a repeated start
  task automatic send_read(input frame_t f);
    recovery_pkg::pec_t crc;
    crc = '0;
    pulse_bus(1'b1);
    send_byte(f.cmd);
    crc8_update(crc, f.cmd);
    send_byte(f.corrupt ? crc ^ 8'h5a : crc);
    pulse_bus(1'b1);
  endtask

  task automatic send_abort(input frame_t f);
    logic seen;
    seen = 1'b0;
    pulse_bus(1'b1);
    send_byte(f.cmd);
    if (f.len > 0) send_byte(8'h10);
    pulse_bus(1'b0);
    repeat (AbortWindow) begin
      @(negedge clk_i);
      if (result_valid_o) seen = 1'b1;
    end
    if (seen || rx_ready_o) begin
      $display("ERROR at %0t: aborted frame gave a result or left the receiver busy", $time);
      errors++;
    end
    step();
  endtask

  initial begin
    int     errors_before;
    int     tests_run;
    frame_t f;
    kind_e  k;
    void'($urandom(97));
    rst_ni        = 1'b0;
    rx_valid_i    = 1'b0;
    rx_data_i     = '0;
    bus_start_i   = 1'b0;
    bus_stop_i    = 1'b0;
    result_ack_i  = 1'b0;
    payload_pop_i = 1'b0;
    errors        = 0;
    failed_tests  = 0;
    tests_run     = 0;
    timed_out     = 1'b0;
    exp_count     = '0;
    repeat (10) @(posedge clk_i);
    #0.5;
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_count(exp_count);
    if (rx_ready_o || result_valid_o || payload_valid_o) begin
      $display("ERROR at %0t: outputs not idle after reset", $time);
      errors++;
    end
    step();
    for (int i = 0; i < NumFrames; i++) begin
      f = Frames[i];
      k = f.kind;
      errors_before = errors;
      if (k == KindAbort) begin
        send_abort(f);
      end else begin
        if (k == KindWrite) send_write(f);
        else send_read(f);
        if (!timed_out) wait_result();
        if (!timed_out) begin
          check_result(f.cmd, (k == KindRead) ? 16'd0 : f.len, k == KindRead, f.corrupt);
          if (f.corrupt) exp_count = exp_count + 1'b1;
          acknowledge();
          drain_payload(f.corrupt);
        end
      end
      tests_run++;
      if (errors != errors_before) failed_tests++;
      $display("Test %0d %s cmd %02h len %0d: %s", i, k.name(), f.cmd, f.len,
               (errors == errors_before) ? "ok" : "failed");
      if (timed_out) break;
    end
    $display("Tests run %0d, failed %0d, errors %0d", tests_run, failed_tests, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

/* filelist.f */
rtl/recovery_pkg.sv
rtl/recovery_cmd_if.sv
rtl/pec_crc8.sv
rtl/recovery_receiver.sv
rtl/payload_queue.sv
rtl/recovery_cmd_handler.sv
rtl/recovery_rx_top.sv
bench/recovery_rx_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= recovery_rx_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := NO ERRORS

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
